// ==== common/cacheGeometryPkg.sv ====
package cacheGeometryPkg;

	localparam int TAG_WIDTH = 8;
	localparam int INDEX_WIDTH = 4;
	localparam int OFFSET_WIDTH = 2;
	localparam int ADDRESS_WIDTH = TAG_WIDTH + INDEX_WIDTH + OFFSET_WIDTH;

	localparam int DATA_WIDTH = 16;
	localparam int LINE_COUNT = 16;

	// tag in the top bits, word offset in the bottom bits
	typedef struct packed {
		logic [TAG_WIDTH - 1 : 0] tag;
		logic [INDEX_WIDTH - 1 : 0] index;
		logic [OFFSET_WIDTH - 1 : 0] offset;
	} cacheAddress;

endpackage : cacheGeometryPkg

// ==== common/coherencePkg.sv ====
package coherencePkg;

	// MODIFIED and OWNED are never produced by this read-only node
	typedef enum logic [2 : 0] {
		INVALID,
		SHARED,
		EXCLUSIVE,
		OWNED,
		MODIFIED,
		FORWARD
	} lineState;

	typedef enum logic [1 : 0] {
		NONE,
		BUS_READ
	} busCommand;

	// fill side writes into the store
	typedef struct packed {
		logic writeData;
		logic writeTag;
		logic writeState;
		lineState stateIn;
		logic [cacheGeometryPkg::DATA_WIDTH - 1 : 0] dataIn;
	} fillWrite;

	typedef struct packed {
		logic writeState;
		lineState stateIn;
	} snoopUpdate;

endpackage : coherencePkg

// ==== controller/blockWordCounter.sv ====
`timescale 1ns/1ps

module blockWordCounter (
	input logic clock,
	input logic reset,
	input logic advance,
	input logic clear,
	output logic [cacheGeometryPkg::OFFSET_WIDTH - 1 : 0] wordIndex,
	output logic lastWord
);

	// wraps back to zero after the final offset
	always_ff @(posedge clock) begin
		if (reset || clear) begin
			wordIndex <= '0;
		end else if (advance) begin
			wordIndex <= wordIndex + 1'b1;
		end
	end

	assign lastWord = &wordIndex;

endmodule : blockWordCounter

// ==== controller/missFsm.sv ====
`timescale 1ns/1ps

module missFsm (
	input logic clock,
	input logic reset,
	input logic cpuReadEnabled,
	input cacheGeometryPkg::cacheAddress cpuAddress,
	input logic cpuHit,
	input logic cpuGrant,
	input logic memFunctionComplete,
	input logic [cacheGeometryPkg::DATA_WIDTH - 1 : 0] memData,
	input logic sharedIn,
	input logic lastWord,
	output logic cpuFunctionComplete,
	output logic accessEnable,
	output logic memReadEnabled,
	output logic advance,
	output logic clear,
	output coherencePkg::busCommand cpuBusCommand,
	output coherencePkg::fillWrite fill
);

	typedef enum logic [1 : 0] {
		IDLE,
		FILLING,
		FINISHING
	} controlPhase;

	typedef enum logic [1 : 0] {
		GRANT_WAIT,
		MEMORY_WAIT,
		WORD_WRITE,
		TAG_STATE_WRITE
	} fillStep;

	controlPhase phase;
	fillStep step;

	// counter moves on in the same cycle the word is written
	assign advance = (phase == FILLING) && (step == WORD_WRITE);
	assign clear = (phase == IDLE);

	always_ff @(posedge clock) begin
		if (reset) begin
			phase <= IDLE;
			step <= GRANT_WAIT;
			cpuFunctionComplete <= 1'b0;
			accessEnable <= 1'b0;
			memReadEnabled <= 1'b0;
			cpuBusCommand <= coherencePkg::NONE;
			fill <= '0;
		end else begin
			case (phase)
				IDLE: begin
					if (cpuReadEnabled) begin
						if (cpuHit) begin
							cpuFunctionComplete <= 1'b1;
							accessEnable <= 1'b1;
							phase <= FINISHING;
						end else begin
							cpuBusCommand <= coherencePkg::BUS_READ;
							step <= GRANT_WAIT;
							phase <= FILLING;
						end
					end
				end

				FILLING: begin
					case (step)
						GRANT_WAIT: begin
							if (cpuGrant) begin
								memReadEnabled <= 1'b1;
								step <= MEMORY_WAIT;
							end
						end

						MEMORY_WAIT: begin
							if (memFunctionComplete) begin
								memReadEnabled <= 1'b0;
								fill.writeData <= 1'b1;
								fill.dataIn <= memData;
								step <= WORD_WRITE;
							end
						end

						WORD_WRITE: begin
							fill.writeData <= 1'b0;
							if (lastWord) begin
								// another holder answered shared, so this copy forwards
								fill.stateIn <= sharedIn ? coherencePkg::FORWARD
									: coherencePkg::EXCLUSIVE;
								fill.writeTag <= 1'b1;
								fill.writeState <= 1'b1;
								step <= TAG_STATE_WRITE;
							end else begin
								step <= GRANT_WAIT;
							end
						end

						TAG_STATE_WRITE: begin
							fill.writeTag <= 1'b0;
							fill.writeState <= 1'b0;
							cpuBusCommand <= coherencePkg::NONE;
							step <= GRANT_WAIT;
							phase <= IDLE;
						end
					endcase
				end

				FINISHING: begin
					cpuFunctionComplete <= 1'b0;
					accessEnable <= 1'b0;
					phase <= IDLE;
				end

				default: phase <= IDLE;
			endcase
		end
	end

	memReadOnlyInFill: assert property (@(posedge clock) disable iff (reset)
		memReadEnabled |-> phase == FILLING);

	completeIsPulse: assert property (@(posedge clock) disable iff (reset)
		cpuFunctionComplete |=> !cpuFunctionComplete);

	// the CPU holds its address for the whole block fill
	addressHeldInFill: assert property (@(posedge clock) disable iff (reset)
		phase == FILLING |=> phase != FILLING || $stable(cpuAddress));

endmodule : missFsm

// ==== logic/cacheStore.sv ====
`timescale 1ns/1ps

module cacheStore (
	input logic clock,
	input logic reset,
	input cacheGeometryPkg::cacheAddress cpuAddress,
	input logic [cacheGeometryPkg::OFFSET_WIDTH - 1 : 0] fillOffset,
	input coherencePkg::fillWrite fill,
	input cacheGeometryPkg::cacheAddress snoopAddress,
	input coherencePkg::snoopUpdate update,
	output logic cpuHit,
	output logic [cacheGeometryPkg::DATA_WIDTH - 1 : 0] cpuData,
	output logic snoopHit,
	output coherencePkg::lineState snoopState,
	output logic [cacheGeometryPkg::DATA_WIDTH - 1 : 0] snoopData
);

	localparam int WORD_COUNT = 2 ** cacheGeometryPkg::OFFSET_WIDTH;

	logic [cacheGeometryPkg::TAG_WIDTH - 1 : 0] tags [cacheGeometryPkg::LINE_COUNT];
	coherencePkg::lineState states [cacheGeometryPkg::LINE_COUNT];
	logic [cacheGeometryPkg::DATA_WIDTH - 1 : 0] words
		[cacheGeometryPkg::LINE_COUNT][WORD_COUNT];

	always_ff @(posedge clock) begin
		if (fill.writeData) begin
			words[cpuAddress.index][fillOffset] <= fill.dataIn;
		end
		if (fill.writeTag) begin
			tags[cpuAddress.index] <= cpuAddress.tag;
		end
	end

	// fill write comes last so it wins on a shared index
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int line = 0; line < cacheGeometryPkg::LINE_COUNT; line++) begin
				states[line] <= coherencePkg::INVALID;
			end
		end else begin
			if (update.writeState) begin
				states[snoopAddress.index] <= update.stateIn;
			end
			if (fill.writeState) begin
				states[cpuAddress.index] <= fill.stateIn;
			end
		end
	end

	assign cpuHit = (tags[cpuAddress.index] == cpuAddress.tag)
		&& (states[cpuAddress.index] != coherencePkg::INVALID);
	assign cpuData = words[cpuAddress.index][cpuAddress.offset];

	assign snoopHit = (tags[snoopAddress.index] == snoopAddress.tag)
		&& (states[snoopAddress.index] != coherencePkg::INVALID);
	assign snoopState = states[snoopAddress.index];
	assign snoopData = words[snoopAddress.index][snoopAddress.offset];

	snoopWriteOnValidLine: assert property (@(posedge clock) disable iff (reset)
		update.writeState |-> states[snoopAddress.index] != coherencePkg::INVALID);

endmodule : cacheStore

// ==== logic/snoopResponder.sv ====
`timescale 1ns/1ps

module snoopResponder (
	input logic clock,
	input logic reset,
	input coherencePkg::busCommand snoopCommand,
	input logic snoopHit,
	input coherencePkg::lineState snoopState,
	input logic snoopGrant,
	input logic snoopReadEnabled,
	output logic sharedOut,
	output logic forwardOut,
	output logic snoopArbiterRequest,
	output logic snoopFunctionComplete,
	output coherencePkg::snoopUpdate update
);

	logic readHit;

	assign readHit = (snoopCommand == coherencePkg::BUS_READ) && snoopHit;

	assign sharedOut = readHit;
	assign forwardOut = readHit && (snoopState == coherencePkg::FORWARD);
	assign snoopArbiterRequest = sharedOut;

	// any held copy drops to shared once another cache reads it
	assign update.writeState = readHit && (snoopState != coherencePkg::SHARED);
	assign update.stateIn = coherencePkg::SHARED;

	always_ff @(posedge clock) begin
		if (reset) begin
			snoopFunctionComplete <= 1'b0;
		end else begin
			snoopFunctionComplete <= readHit && snoopGrant && snoopReadEnabled;
		end
	end

	completeAfterReadHit: assert property (@(posedge clock) disable iff (reset)
		snoopFunctionComplete |-> $past(snoopCommand == coherencePkg::BUS_READ && snoopHit));

endmodule : snoopResponder

// ==== logic/coherentCache.sv ====
`timescale 1ns/1ps

module coherentCache (
	input logic clock,
	input logic reset,

	input cacheGeometryPkg::cacheAddress cpuAddress,
	input logic cpuReadEnabled,
	output logic cpuFunctionComplete,
	output logic [cacheGeometryPkg::DATA_WIDTH - 1 : 0] cpuData,
	output logic accessEnable,

	output coherencePkg::busCommand cpuBusCommand,
	input logic cpuGrant,
	output logic memReadEnabled,
	output logic [cacheGeometryPkg::ADDRESS_WIDTH - 1 : 0] memAddress,
	input logic memFunctionComplete,
	input logic [cacheGeometryPkg::DATA_WIDTH - 1 : 0] memData,
	input logic sharedIn,

	input coherencePkg::busCommand snoopCommand,
	input cacheGeometryPkg::cacheAddress snoopAddress,
	output logic sharedOut,
	output logic forwardOut,
	output logic snoopArbiterRequest,
	input logic snoopGrant,
	input logic snoopReadEnabled,
	output logic snoopFunctionComplete,
	output logic [cacheGeometryPkg::DATA_WIDTH - 1 : 0] snoopData
);

	logic cpuHit;
	logic advance;
	logic clear;
	logic lastWord;
	logic [cacheGeometryPkg::OFFSET_WIDTH - 1 : 0] wordIndex;
	coherencePkg::fillWrite fill;
	logic snoopHit;
	coherencePkg::lineState snoopState;
	coherencePkg::snoopUpdate update;

	// block address of the request with the current fill word
	assign memAddress = {cpuAddress.tag, cpuAddress.index, wordIndex};

	missFsm controller (
		.clock(clock),
		.reset(reset),
		.cpuReadEnabled(cpuReadEnabled),
		.cpuAddress(cpuAddress),
		.cpuHit(cpuHit),
		.cpuGrant(cpuGrant),
		.memFunctionComplete(memFunctionComplete),
		.memData(memData),
		.sharedIn(sharedIn),
		.lastWord(lastWord),
		.cpuFunctionComplete(cpuFunctionComplete),
		.accessEnable(accessEnable),
		.memReadEnabled(memReadEnabled),
		.advance(advance),
		.clear(clear),
		.cpuBusCommand(cpuBusCommand),
		.fill(fill)
	);

	blockWordCounter counter (
		.clock(clock),
		.reset(reset),
		.advance(advance),
		.clear(clear),
		.wordIndex(wordIndex),
		.lastWord(lastWord)
	);

	cacheStore store (
		.clock(clock),
		.reset(reset),
		.cpuAddress(cpuAddress),
		.fillOffset(wordIndex),
		.fill(fill),
		.snoopAddress(snoopAddress),
		.update(update),
		.cpuHit(cpuHit),
		.cpuData(cpuData),
		.snoopHit(snoopHit),
		.snoopState(snoopState),
		.snoopData(snoopData)
	);

	snoopResponder responder (
		.clock(clock),
		.reset(reset),
		.snoopCommand(snoopCommand),
		.snoopHit(snoopHit),
		.snoopState(snoopState),
		.snoopGrant(snoopGrant),
		.snoopReadEnabled(snoopReadEnabled),
		.sharedOut(sharedOut),
		.forwardOut(forwardOut),
		.snoopArbiterRequest(snoopArbiterRequest),
		.snoopFunctionComplete(snoopFunctionComplete),
		.update(update)
	);

endmodule : coherentCache

// ==== tests/coherentCacheTb.sv ====
`timescale 1ns/1ps

module coherentCacheTb;

	localparam int TIMEOUT_CYCLES = 40;
	localparam logic [15 : 0] DATA_MASK = 16'h5A3C;

	logic clock;
	logic reset;
	cacheGeometryPkg::cacheAddress cpuAddress;
	logic cpuReadEnabled;
	logic cpuFunctionComplete;
	logic [cacheGeometryPkg::DATA_WIDTH - 1 : 0] cpuData;
	logic accessEnable;
	coherencePkg::busCommand cpuBusCommand;
	logic cpuGrant;
	logic memReadEnabled;
	logic [cacheGeometryPkg::ADDRESS_WIDTH - 1 : 0] memAddress;
	logic memFunctionComplete;
	logic [cacheGeometryPkg::DATA_WIDTH - 1 : 0] memData;
	logic sharedIn;
	coherencePkg::busCommand snoopCommand;
	cacheGeometryPkg::cacheAddress snoopAddress;
	logic sharedOut;
	logic forwardOut;
	logic snoopArbiterRequest;
	logic snoopGrant;
	logic snoopReadEnabled;
	logic snoopFunctionComplete;
	logic [cacheGeometryPkg::DATA_WIDTH - 1 : 0] snoopData;

	integer seed;
	cacheGeometryPkg::cacheAddress exclusiveLine;
	cacheGeometryPkg::cacheAddress forwardLine;

	coherentCache uut (
		.clock(clock),
		.reset(reset),
		.cpuAddress(cpuAddress),
		.cpuReadEnabled(cpuReadEnabled),
		.cpuFunctionComplete(cpuFunctionComplete),
		.cpuData(cpuData),
		.accessEnable(accessEnable),
		.cpuBusCommand(cpuBusCommand),
		.cpuGrant(cpuGrant),
		.memReadEnabled(memReadEnabled),
		.memAddress(memAddress),
		.memFunctionComplete(memFunctionComplete),
		.memData(memData),
		.sharedIn(sharedIn),
		.snoopCommand(snoopCommand),
		.snoopAddress(snoopAddress),
		.sharedOut(sharedOut),
		.forwardOut(forwardOut),
		.snoopArbiterRequest(snoopArbiterRequest),
		.snoopGrant(snoopGrant),
		.snoopReadEnabled(snoopReadEnabled),
		.snoopFunctionComplete(snoopFunctionComplete),
		.snoopData(snoopData)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// memory contents follow the word address
	function automatic logic [15 : 0] memoryWord(input logic [13 : 0] address);
		return {2'b00, address} ^ DATA_MASK;
	endfunction

	function automatic cacheGeometryPkg::cacheAddress makeAddress(input logic [7 : 0] tag,
		input logic [3 : 0] index, input logic [1 : 0] offset);
		cacheGeometryPkg::cacheAddress address;
		address.tag = tag;
		address.index = index;
		address.offset = offset;
		return address;
	endfunction

	function automatic int randomDelay(input int limit);
		return $unsigned($random(seed)) % limit;
	endfunction

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Test FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic checkValue(input string testName, input logic [31 : 0] expected,
		input logic [31 : 0] actual);
		if (actual !== expected) begin
			failRun($sformatf("ERROR %s: expected 0x%0h, actual 0x%0h",
				testName, expected, actual));
		end
	endtask

	// plays arbiter and memory for all four words of the block
	task automatic readMiss(input string testName, input cacheGeometryPkg::cacheAddress address,
		input logic shared);
		cacheGeometryPkg::cacheAddress expectedAddress;
		int cycles;
		@(negedge clock);
		cpuAddress = address;
		cpuReadEnabled = 1'b1;
		sharedIn = shared;
		for (int word = 0; word < 4; word++) begin
			cycles = 0;
			while (cpuBusCommand != coherencePkg::BUS_READ) begin
				@(negedge clock);
				cycles++;
				if (cycles > TIMEOUT_CYCLES) begin
					failRun("the cache never requested the bus for its miss");
				end
			end
			repeat (randomDelay(3)) @(negedge clock);
			cpuGrant = 1'b1;
			cycles = 0;
			while (!memReadEnabled) begin
				@(negedge clock);
				cycles++;
				if (cycles > TIMEOUT_CYCLES) begin
					failRun("the cache never started a memory read after its grant");
				end
			end
			cpuGrant = 1'b0;
			expectedAddress = address;
			expectedAddress.offset = word[1 : 0];
			checkValue(testName, expectedAddress, memAddress);
			repeat (1 + randomDelay(3)) @(negedge clock);
			memData = memoryWord(memAddress);
			memFunctionComplete = 1'b1;
			@(negedge clock);
			memFunctionComplete = 1'b0;
		end
		// the bus stays granted so that an extra word read would show up
		cpuGrant = 1'b1;
		cycles = 0;
		while (!cpuFunctionComplete) begin
			@(negedge clock);
			cycles++;
			if (memReadEnabled) begin
				failRun("the cache started a fifth memory read for one block");
			end
			if (cycles > TIMEOUT_CYCLES) begin
				failRun("the read miss never completed after the block fill");
			end
		end
		cpuGrant = 1'b0;
		checkValue(testName, 1, accessEnable);
		checkValue(testName, coherencePkg::NONE, cpuBusCommand);
		checkValue(testName, memoryWord(address), cpuData);
		cpuReadEnabled = 1'b0;
		sharedIn = 1'b0;
		@(negedge clock);
		checkValue(testName, 0, cpuFunctionComplete);
	endtask

	task automatic readHit(input string testName, input cacheGeometryPkg::cacheAddress address);
		@(negedge clock);
		cpuAddress = address;
		cpuReadEnabled = 1'b1;
		// a hit completes on the first edge
		@(negedge clock);
		checkValue(testName, 1, cpuFunctionComplete);
		checkValue(testName, 1, accessEnable);
		checkValue(testName, 0, memReadEnabled);
		checkValue(testName, coherencePkg::NONE, cpuBusCommand);
		checkValue(testName, memoryWord(address), cpuData);
		cpuReadEnabled = 1'b0;
		@(negedge clock);
		checkValue(testName, 0, cpuFunctionComplete);
		checkValue(testName, 0, accessEnable);
	endtask

	task automatic snoopRead(input string testName, input cacheGeometryPkg::cacheAddress address,
		input logic granted, input logic shared, input logic forward);
		@(negedge clock);
		snoopCommand = coherencePkg::BUS_READ;
		snoopAddress = address;
		snoopGrant = granted;
		snoopReadEnabled = granted;
		#1;
		checkValue(testName, shared, sharedOut);
		checkValue(testName, forward, forwardOut);
		checkValue(testName, shared, snoopArbiterRequest);
		@(negedge clock);
		checkValue(testName, granted && shared, snoopFunctionComplete);
		if (granted && shared) begin
			checkValue(testName, memoryWord(address), snoopData);
		end
		snoopCommand = coherencePkg::NONE;
		snoopGrant = 1'b0;
		snoopReadEnabled = 1'b0;
	endtask

	task automatic resetStateTest();
		@(negedge clock);
		checkValue("reset state", 0, cpuFunctionComplete);
		checkValue("reset state", 0, accessEnable);
		checkValue("reset state", 0, memReadEnabled);
		checkValue("reset state", 0, snoopFunctionComplete);
		checkValue("reset state", coherencePkg::NONE, cpuBusCommand);
		snoopRead("reset state", exclusiveLine, 1'b1, 1'b0, 1'b0);
		snoopRead("reset state", forwardLine, 1'b1, 1'b0, 1'b0);
		snoopRead("reset state", makeAddress(8'h00, 4'h0, 2'd0), 1'b0, 1'b0, 1'b0);
	endtask

	task automatic exclusiveFillTest();
		readMiss("exclusive fill", exclusiveLine, 1'b0);
		snoopRead("exclusive fill", exclusiveLine, 1'b0, 1'b1, 1'b0);
	endtask

	task automatic lineHitTest();
		readHit("line hit", makeAddress(exclusiveLine.tag, exclusiveLine.index, 2'd0));
		readHit("line hit", makeAddress(exclusiveLine.tag, exclusiveLine.index, 2'd1));
		readHit("line hit", makeAddress(exclusiveLine.tag, exclusiveLine.index, 2'd3));
	endtask

	task automatic forwardFillTest();
		readMiss("forward fill", forwardLine, 1'b1);
	endtask

	// first snoop sees Forward and gets the word, second sees the downgrade
	task automatic forwardSupplyTest();
		snoopRead("forward supply", forwardLine, 1'b1, 1'b1, 1'b1);
		snoopRead("forward supply", forwardLine, 1'b0, 1'b1, 1'b0);
	endtask

	task automatic snoopMissTest();
		cacheGeometryPkg::cacheAddress address;
		logic [31 : 0] randomBits;
		for (int trial = 0; trial < 8; trial++) begin
			randomBits = $random(seed);
			address = randomBits[13 : 0];
			if (address.tag == exclusiveLine.tag && address.index == exclusiveLine.index) begin
				address.tag = ~address.tag;
			end
			if (address.tag == forwardLine.tag && address.index == forwardLine.index) begin
				address.tag = ~address.tag;
			end
			snoopRead("snoop miss", address, 1'b1, 1'b0, 1'b0);
		end
	endtask

	initial begin
		seed = 46757;
		exclusiveLine = makeAddress(8'hA5, 4'h3, 2'd2);
		forwardLine = makeAddress(8'h3C, 4'h9, 2'd1);
		reset = 1'b1;
		cpuAddress = '0;
		cpuReadEnabled = 1'b0;
		cpuGrant = 1'b0;
		memFunctionComplete = 1'b0;
		memData = '0;
		sharedIn = 1'b0;
		snoopCommand = coherencePkg::NONE;
		snoopAddress = '0;
		snoopGrant = 1'b0;
		snoopReadEnabled = 1'b0;
		repeat (5) @(negedge clock);
		reset = 1'b0;

		resetStateTest();
		exclusiveFillTest();
		lineHitTest();
		forwardFillTest();
		forwardSupplyTest();
		snoopMissTest();

		$display("Test OK");
		$finish;
	end

endmodule : coherentCacheTb

// ==== build.f ====
common/cacheGeometryPkg.sv
common/coherencePkg.sv
controller/blockWordCounter.sv
controller/missFsm.sv
logic/cacheStore.sv
logic/snoopResponder.sv
logic/coherentCache.sv
tests/coherentCacheTb.sv
